/* design/io_addr_decode.sv */
`timescale 1ns/100ps

module io_addr_decode
    import uart_io_pkg::*;
(
    input  logic         Clock,
    input  logic         arst_n,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  logic [31:0]  wb_adr,
    input  logic [31:0]  wb_dat_w,
    input  logic [3:0]   wb_sel,
    input  uart_status_t status,
    output io_req_t      req,
    output logic         wb_ack
);

    logic       bus_req;
    logic       pending;
    logic       hit_status;
    logic       hit_rxdata;
    logic       hit_txdata;
    logic       tx_hold;
    logic       issue;
    logic [7:0] lane_byte;

    assign bus_req    = wb_cyc & wb_stb;
    assign hit_status = (wb_adr == STATUS_ADDR);
    assign hit_rxdata = (wb_adr == RXDATA_ADDR);
    assign hit_txdata = (wb_adr == TXDATA_ADDR);

    // Transmit writes wait here until the transmitter is idle
    assign tx_hold = wb_we & hit_txdata & ~status.tx_ready;

    // One request per bus cycle, ack follows on the next edge
    assign issue = bus_req & ~pending & ~tx_hold;

    // Lowest set select bit wins the lane
    always_comb
    begin
        if (wb_sel[0])
            lane_byte = wb_dat_w[7:0];
        else if (wb_sel[1])
            lane_byte = wb_dat_w[15:8];
        else if (wb_sel[2])
            lane_byte = wb_dat_w[23:16];
        else if (wb_sel[3])
            lane_byte = wb_dat_w[31:24];
        else
            lane_byte = wb_dat_w[7:0];
    end

    always_comb
    begin
        req.rd_status = issue & ~wb_we & hit_status;
        req.rd_rxdata = issue & ~wb_we & hit_rxdata;
        req.wr_tx     = issue & wb_we & hit_txdata;
        req.tx_byte   = lane_byte;
    end

    // --------------------
    // Handshake state
    // --------------------

    // Pending stays set until the master drops stb after its ack
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pending <= 1'b0;
            wb_ack  <= 1'b0;
        end
        else
        begin
            wb_ack <= issue;
            if (!bus_req)
                pending <= 1'b0;
            else if (issue)
                pending <= 1'b1;
        end
    end

endmodule

/* design/io_read_mux.sv */
`timescale 1ns/100ps

module io_read_mux
    import uart_io_pkg::*;
(
    input  logic         Clock,
    input  logic         arst_n,
    input  io_req_t      req,
    input  uart_status_t status,
    output logic [31:0]  wb_dat_r
);

    logic [31:0] next_word;

    // --------------------
    // Read data select
    // --------------------

    // Anything not decoded as a read gives zero
    always_comb
    begin
        next_word = '0;
        if (req.rd_status)
        begin
            next_word[STAT_TX_READY] = status.tx_ready;
            next_word[STAT_RX_VALID] = status.rx_valid;
        end
        else if (req.rd_rxdata && status.rx_valid)
        begin
            // Empty receive register reads as zero
            next_word[7:0] = status.rx_byte;
        end
    end

    // Registered on the request cycle so data lines up with ack
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
            wb_dat_r <= '0;
        else
            wb_dat_r <= next_word;
    end

endmodule

/* design/uart_io_pkg.sv */
package uart_io_pkg;

    // --------------------
    // Register map
    // --------------------

    // Word addresses on the data bus
    localparam logic [31:0] STATUS_ADDR = 32'h8000_0000;
    localparam logic [31:0] RXDATA_ADDR = 32'h8000_0004;
    localparam logic [31:0] TXDATA_ADDR = 32'h8000_0008;

    // Bit positions in the status word
    localparam int STAT_TX_READY = 0;
    localparam int STAT_RX_VALID = 1;

    // --------------------
    // Internal buses
    // --------------------

    // Decoder to datapath, valid for one cycle before ack
    typedef struct packed {
        // Read of the status register
        logic       rd_status;
        // Read of the receive data register, also consumes the byte
        logic       rd_rxdata;
        // Load strobe for the transmitter
        logic       wr_tx;
        // Byte lane picked by the lowest set select bit
        logic [7:0] tx_byte;
    } io_req_t;

    // UART state seen by the decoder and the read stage
    typedef struct packed {
        // Transmitter idle and able to take a byte
        logic       tx_ready;
        // A received byte is being held
        logic       rx_valid;
        // The held byte
        logic [7:0] rx_byte;
    } uart_status_t;

endpackage

/* design/uart_io_top.sv */
`timescale 1ns/100ps

module uart_io_top
    import uart_io_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic        Clock,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        ser_in,
    output logic        ser_out
);

    io_req_t      req;
    uart_status_t status;
    logic         tx_ready;
    logic         rx_valid;
    logic [7:0]   rx_byte;

    // Collect both UART halves into one status bundle
    assign status = '{tx_ready: tx_ready, rx_valid: rx_valid, rx_byte: rx_byte};

    io_addr_decode io_addr_decode_i (
        .Clock    (Clock),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .status   (status),
        .req      (req),
        .wb_ack   (wb_ack)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_tx_i (
        .Clock    (Clock),
        .arst_n   (arst_n),
        .req      (req),
        .tx_ready (tx_ready),
        .ser_out  (ser_out)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_rx_i (
        .Clock    (Clock),
        .arst_n   (arst_n),
        .ser_in   (ser_in),
        .req      (req),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    io_read_mux io_read_mux_i (
        .Clock    (Clock),
        .arst_n   (arst_n),
        .req      (req),
        .status   (status),
        .wb_dat_r (wb_dat_r)
    );

endmodule

/* design/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx
    import uart_io_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic       Clock,
    input  logic       arst_n,
    input  logic       ser_in,
    input  io_req_t    req,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    localparam int               CNT_W     = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_last;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift;
    logic             bit_end;
    logic             byte_done;

    // --------------------
    // Synchronizer
    // --------------------

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end
        else
        begin
            rx_meta <= ser_in;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    // Half a bit for the start check, a full bit afterwards
    assign bit_end   = (state == RX_START) ? (baud_cnt == HALF_LAST)
                                           : (baud_cnt == BAUD_LAST);
    assign byte_done = (state == RX_STOP) & bit_end & rx_sync;

    // --------------------
    // Frame FSM
    // --------------------

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                RX_IDLE:
                begin
                    baud_cnt <= '0;
                    if (rx_last && !rx_sync)
                        state <= RX_START;
                end
                RX_START:
                begin
                    // A glitch shorter than half a bit goes back to idle
                    if (bit_end)
                    begin
                        bit_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA:
                begin
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                end
                default:
                begin
                    // Stop bit sampled, bad frames are simply dropped
                    if (bit_end)
                        state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge Clock)
    begin
        if (state == RX_DATA && bit_end)
            shift <= {rx_sync, shift[7:1]};
        if (byte_done)
            rx_byte <= shift;
    end

    // A new byte wins over a read in the same cycle
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
            rx_valid <= 1'b0;
        else if (byte_done)
            rx_valid <= 1'b1;
        else if (req.rd_rxdata)
            rx_valid <= 1'b0;
    end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx
    import uart_io_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic    Clock,
    input  logic    arst_n,
    input  io_req_t req,
    output logic    tx_ready,
    output logic    ser_out
);

    localparam int               CNT_W     = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(CLKS_PER_BIT - 1);
    // Start, eight data bits, stop
    localparam logic [3:0]       LAST_BIT  = 4'd9;

    logic             busy;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       frame;
    logic             bit_end;

    assign bit_end  = (baud_cnt == BAUD_LAST);
    assign tx_ready = ~busy;

    // Line is driven straight from the bottom of the frame register
    assign ser_out = frame[0];

    // --------------------
    // Frame shifter
    // --------------------

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // All ones keeps the line idle high
            frame    <= '1;
        end
        else if (!busy)
        begin
            if (req.wr_tx)
            begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
                frame    <= {1'b1, req.tx_byte, 1'b0};
            end
        end
        else if (bit_end)
        begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
            // Shift in ones so the line returns high after stop
            frame    <= {1'b1, frame[9:1]};
            if (bit_cnt == LAST_BIT)
                busy <= 1'b0;
        end
        else
        begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module uart_io_tb -Mdir obj_dir -f uart_io.f || exit 1
./obj_dir/Vuart_io_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation passed" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

/* sim/uart_io_sva.sv */
`timescale 1ns/100ps

module uart_io_sva
(
    input logic Clock,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic ser_out
);

    // --------------------
    // Wishbone handshake
    // --------------------

    // Ack only answers a live strobe
    ack_needs_strobe: assert property (
        @(posedge Clock) disable iff (!arst_n) wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb_ack high without wb_cyc and wb_stb");

    ack_single_cycle: assert property (
        @(posedge Clock) disable iff (!arst_n) wb_ack |=> !wb_ack
    ) else $error("wb_ack high for two cycles in a row");

    // --------------------
    // Serial line
    // --------------------

    idle_in_reset: assert property (
        @(posedge Clock) !arst_n |-> ser_out
    ) else $error("ser_out low while reset is active");

    // First cycle out of reset
    idle_after_reset: assert property (
        @(posedge Clock) $rose(arst_n) |-> ser_out
    ) else $error("ser_out low right after reset");

endmodule

bind uart_io_top uart_io_sva uart_io_sva_i (
    .Clock   (Clock),
    .arst_n  (arst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .ser_out (ser_out)
);

/* sim/uart_io_tb.sv */
`timescale 1ns/100ps

module uart_io_tb
    import uart_io_pkg::*;
();

    localparam int CLKS_PER_BIT    = 16;
    localparam int FRAME_CYCLES    = 10 * CLKS_PER_BIT;
    localparam int ACK_LIMIT       = 20 * CLKS_PER_BIT;
    // 22 frames out on ser_out and 23 frames in on ser_in
    localparam int NUM_FRAMES      = 45;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES * 3 / 2 + 2000;

    localparam uart_status_t IDLE_STATUS = '{tx_ready: 1'b1, rx_valid: 1'b0, rx_byte: 8'h00};
    localparam uart_status_t BUSY_STATUS = '{tx_ready: 1'b0, rx_valid: 1'b0, rx_byte: 8'h00};

    logic        Clock  = 1'b0;
    logic        arst_n = 1'b1;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        ser_in;
    logic        ser_out;

    logic [31:0] rng_state = 32'h069f_d176;
    logic [7:0]  mon_byte;
    logic [7:0]  tx_seen[$];
    logic [7:0]  tx_expect[$];

    uart_io_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_io_top_i (
        .Clock    (Clock),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ser_in   (ser_in),
        .ser_out  (ser_out)
    );

    always #5 Clock = ~Clock;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // Byte lane model where the first set select bit from the bottom wins
    function automatic logic [7:0] expected_lane(input logic [31:0] data, input logic [3:0] sel);
        logic [7:0] lane;
        logic       found;
        lane  = data[7:0];
        found = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (sel[i] && !found)
            begin
                lane  = data[8*i +: 8];
                found = 1'b1;
            end
        end
        return lane;
    endfunction

    // Status word bits 9:2 land in rx_byte
    function automatic uart_status_t to_status(input logic [31:0] word);
        uart_status_t s;
        s.tx_ready = word[STAT_TX_READY];
        s.rx_valid = word[STAT_RX_VALID];
        s.rx_byte  = word[9:2];
        return s;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            stop_with_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_with_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input uart_status_t exp,
                                input uart_status_t act);
        if (act !== exp)
            stop_with_error($sformatf(
                "mismatch %s: expected %h, actual %h (tx_ready %b rx_valid %b)",
                name, exp, act, act.tx_ready, act.rx_valid));
    endtask

    // --------------------
    // Bus tasks
    // --------------------

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge Clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(negedge Clock);
        while (!wb_ack)
        begin
            waited++;
            if (waited > ACK_LIMIT)
                stop_with_error($sformatf("missing acknowledge on read of %h", adr));
            @(negedge Clock);
        end
        data = wb_dat_r;
        @(posedge Clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] data,
                            input logic [3:0] sel, output int waited);
        waited = 0;
        @(posedge Clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wb_sel   <= sel;
        @(negedge Clock);
        while (!wb_ack)
        begin
            waited++;
            if (waited > ACK_LIMIT)
                stop_with_error($sformatf("missing acknowledge on write to %h", adr));
            @(negedge Clock);
        end
        @(posedge Clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // --------------------
    // Serial line model
    // --------------------

    // Start, data LSB first, stop, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge Clock);
            ser_in <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge Clock);
        end
        @(posedge Clock);
        ser_in <= 1'b1;
        repeat (CLKS_PER_BIT - 1) @(posedge Clock);
    endtask

    // Decode ser_out at mid-bit on falling clock edges
    always
    begin
        @(negedge ser_out);
        repeat (CLKS_PER_BIT / 2) @(negedge Clock);
        if (ser_out !== 1'b0)
            stop_with_error("start bit on ser_out ended early");
        for (int i = 0; i < 8; i++)
        begin
            repeat (CLKS_PER_BIT) @(negedge Clock);
            mon_byte[i] = ser_out;
        end
        repeat (CLKS_PER_BIT) @(negedge Clock);
        if (ser_out !== 1'b1)
            stop_with_error("stop bit on ser_out is low");
        tx_seen.push_back(mon_byte);
    end

    task automatic take_tx_byte(output logic [7:0] got);
        int waited;
        waited = 0;
        while (tx_seen.size() == 0)
        begin
            @(negedge Clock);
            waited++;
            if (waited > 2 * FRAME_CYCLES)
                stop_with_error("no byte came out of ser_out");
        end
        got = tx_seen.pop_front();
    endtask

    task automatic wait_rx_valid(input string name);
        logic [31:0] word;
        int          polls;
        polls = 0;
        wb_read(STATUS_ADDR, word);
        while (!word[STAT_RX_VALID])
        begin
            polls++;
            if (polls > 8)
                stop_with_error($sformatf("rx_valid never set in %s", name));
            wb_read(STATUS_ADDR, word);
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge Clock);
        stop_with_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial
    begin
        logic [31:0] word;
        logic [31:0] r;
        logic [31:0] data_word;
        logic [3:0]  sel;
        logic [7:0]  got;
        logic [7:0]  exp_byte;
        logic [7:0]  first;
        logic [7:0]  second;
        int          waited;
        arst_n   <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        wb_sel   <= '0;
        ser_in   <= 1'b1;
        repeat (10) @(posedge Clock);
        arst_n <= 1'b1;
        repeat (2) @(posedge Clock);

        // Reset values and an unmapped read
        wb_read(STATUS_ADDR, word);
        check_status("reset status", IDLE_STATUS, to_status(word));
        wb_read(32'h8000_0010, word);
        check_word("unmapped read", 32'h0, word);

        // Random transmit bytes with random byte-selects
        for (int n = 0; n < 20; n++)
        begin
            draw_random(data_word);
            draw_random(r);
            sel = r[3:0];
            if (sel == 4'h0)
                sel = 4'h1 << r[5:4];
            wb_write(TXDATA_ADDR, data_word, sel, waited);
            tx_expect.push_back(expected_lane(data_word, sel));
        end
        for (int n = 0; n < 20; n++)
        begin
            take_tx_byte(got);
            exp_byte = tx_expect.pop_front();
            check_byte("tx random byte", exp_byte, got);
        end

        // Back to back writes where the second waits behind the first frame
        draw_random(r);
        first  = r[7:0];
        second = r[15:8];
        wb_write(TXDATA_ADDR, {24'h0, first}, 4'h1, waited);
        wb_write(TXDATA_ADDR, {16'h0, second, 8'h0}, 4'h2, waited);
        if (waited < FRAME_CYCLES / 2)
            stop_with_error("second transmit write was not held off");
        wb_read(STATUS_ADDR, word);
        check_status("tx busy status", BUSY_STATUS, to_status(word));
        take_tx_byte(got);
        check_byte("tx back to back first", first, got);
        take_tx_byte(got);
        check_byte("tx back to back second", second, got);

        // Random receive bytes
        for (int n = 0; n < 20; n++)
        begin
            draw_random(r);
            send_frame(r[7:0], 1'b1);
            wait_rx_valid("rx random byte");
            wb_read(RXDATA_ADDR, word);
            check_word("rx random byte", {24'h0, r[7:0]}, word);
            wb_read(STATUS_ADDR, word);
            check_status("rx status after read", IDLE_STATUS, to_status(word));
            wb_read(RXDATA_ADDR, word);
            check_word("rx empty read", 32'h0, word);
        end

        // Second frame carries the inverted byte and overwrites the held one
        draw_random(r);
        send_frame(r[7:0], 1'b1);
        send_frame(~r[7:0], 1'b1);
        wait_rx_valid("rx overwrite");
        wb_read(RXDATA_ADDR, word);
        check_word("rx overwrite", {24'h0, ~r[7:0]}, word);

        // A frame with a low stop bit is dropped
        draw_random(r);
        send_frame(r[7:0], 1'b0);
        repeat (CLKS_PER_BIT) @(posedge Clock);
        wb_read(STATUS_ADDR, word);
        check_status("rx framing error", IDLE_STATUS, to_status(word));
        wb_read(RXDATA_ADDR, word);
        check_word("rx framing error data", 32'h0, word);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* uart_io.f */
design/uart_io_pkg.sv
design/io_addr_decode.sv
design/uart_tx.sv
design/uart_rx.sv
design/io_read_mux.sv
design/uart_io_top.sv
sim/uart_io_sva.sv
sim/uart_io_tb.sv
